//--- mempool_group.f
+incdir+common
common/group_pkg.sv
common/tcdm_if.sv
interco/rr_arbiter.sv
interco/local_interco.sv
tile/tcdm_bank.sv
verilog/mempool_group.sv
bench/mempool_group_checker.sv
bench/tb_mempool_group.sv

//--- Bender.yml
package:
  name: mempool_group

export_include_dirs:
  - common

sources:
  - files:
      - common/group_pkg.sv
      - common/tcdm_if.sv
      - interco/rr_arbiter.sv
      - interco/local_interco.sv
      - tile/tcdm_bank.sv
      - verilog/mempool_group.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/mempool_group_checker.sv
      - bench/tb_mempool_group.sv

//--- bench/tb_mempool_group.sv
/*
 * Testbench for the MemPool group
 * Directed tests on the core ports against a reference memory
 */

`default_nettype none

`include "group_params.svh"

module tb_mempool_group;

  localparam int NT            = `NUM_TILES;
  localparam int MaxOps        = 128;
  localparam int WaitLimit     = 50;
  localparam int BatchLimit    = 4000;
  localparam int MemWords      = NT * `BANK_WORDS;

  logic                                  clk;
  logic                                  rst_n;
  logic                  [NT-1:0]        req_valid;
  logic                  [NT-1:0]        req_ready_o;
  group_pkg::tcdm_addr_t [NT-1:0]        req_tgt_addr;
  logic                  [NT-1:0]        req_wen;
  group_pkg::data_t      [NT-1:0]        req_wdata;
  group_pkg::strb_t      [NT-1:0]        req_be;
  logic                  [NT-1:0]        resp_valid_o;
  logic                  [NT-1:0]        resp_ready;
  group_pkg::data_t      [NT-1:0]        resp_rdata_o;

  group_pkg::data_t ref_mem [MemWords];
  logic [15:0]      lfsr;
  int               errors;
  int               tests_run;
  int               tests_failed;

  // Per-initiator operation lists for the batch engine
  group_pkg::tcdm_addr_t op_addr  [NT][MaxOps];
  logic                  op_wen   [NT][MaxOps];
  group_pkg::data_t      op_wdata [NT][MaxOps];
  group_pkg::strb_t      op_be    [NT][MaxOps];
  int                    op_cnt   [NT];

  mempool_group dut0 (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready_o),
    .req_tgt_addr_i (req_tgt_addr),
    .req_wen_i      (req_wen),
    .req_wdata_i    (req_wdata),
    .req_be_i       (req_be),
    .resp_valid_o   (resp_valid_o),
    .resp_ready_i   (resp_ready),
    .resp_rdata_o   (resp_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp_val,
                          input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic ref_write(input group_pkg::tcdm_addr_t addr, input group_pkg::data_t wdata,
                           input group_pkg::strb_t be);
    for (int k = 0; k < group_pkg::StrbW; k++) begin
      if (be[k]) begin
        ref_mem[addr][8*k +: 8] = wdata[8*k +: 8];
      end
    end
  endtask

  task automatic drive_req(input int ini, input group_pkg::tcdm_addr_t addr, input logic wen,
                           input group_pkg::data_t wdata, input group_pkg::strb_t be);
    req_valid[ini]    <= 1'b1;
    req_tgt_addr[ini] <= addr;
    req_wen[ini]      <= wen;
    req_wdata[ini]    <= wdata;
    req_be[ini]       <= be;
  endtask

  task automatic wait_ready(input int ini, input string name);
    logic ok;
    ok = 1'b0;
    for (int n = 0; n < WaitLimit && !ok; n++) begin
      @(posedge clk);
      ok = req_ready_o[ini];
    end
    if (!ok) begin
      $display("%s: request of initiator %0d was never accepted", name, ini);
      errors++;
    end
  endtask

  task automatic wait_resp(input int ini, input string name);
    logic ok;
    ok = 1'b0;
    for (int n = 0; n < WaitLimit && !ok; n++) begin
      @(posedge clk);
      ok = resp_valid_o[ini];
    end
    if (!ok) begin
      $display("%s: no response arrived at initiator %0d", name, ini);
      errors++;
    end
  endtask

  task automatic clear_ops();
    for (int i = 0; i < NT; i++) begin
      op_cnt[i] = 0;
    end
  endtask

  task automatic add_op(input int ini, input group_pkg::tcdm_addr_t addr, input logic wen,
                        input group_pkg::data_t wdata, input group_pkg::strb_t be);
    if (op_cnt[ini] == MaxOps) begin
      $display("operation list of initiator %0d is full", ini);
      errors++;
    end else begin
      op_addr[ini][op_cnt[ini]]  = addr;
      op_wen[ini][op_cnt[ini]]   = wen;
      op_wdata[ini][op_cnt[ini]] = wdata;
      op_be[ini][op_cnt[ini]]    = be;
      op_cnt[ini]++;
    end
  endtask

  // ----------------------------------------
  // Batch engine with one outstanding per initiator
  // ----------------------------------------

  task automatic run_ops(input string name, input bit fair_chk);
    int               state [NT];
    int               issued [NT];
    int               done [NT];
    group_pkg::data_t exp_data [NT];
    logic             is_read [NT];
    int               cycles;
    int               cur;
    bit               busy;
    for (int i = 0; i < NT; i++) begin
      state[i]  = 0;
      issued[i] = 0;
      done[i]   = 0;
    end
    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      @(posedge clk);
      cycles++;
      busy = 1'b0;
      for (int i = 0; i < NT; i++) begin
        if (state[i] == 2 && resp_valid_o[i]) begin
          if (is_read[i]) begin
            check_eq(name, exp_data[i], resp_rdata_o[i]);
          end
          if (fair_chk && done[i] > 0) begin
            for (int j = 0; j < NT; j++) begin
              if (done[j] == 0 && op_cnt[j] > 0) begin
                $display("%s: initiator %0d served twice before initiator %0d", name, i, j);
                errors++;
              end
            end
          end
          done[i]++;
          state[i] = 0;
        end else if (state[i] == 1 && req_ready_o[i]) begin
          // Acceptance order is bank order and a write returns old data
          cur         = issued[i];
          exp_data[i] = ref_mem[op_addr[i][cur]];
          is_read[i]  = !op_wen[i][cur];
          if (op_wen[i][cur]) begin
            ref_write(op_addr[i][cur], op_wdata[i][cur], op_be[i][cur]);
          end
          issued[i]++;
          req_valid[i] <= 1'b0;
          state[i] = 2;
        end
        if (state[i] == 0 && issued[i] < op_cnt[i]) begin
          cur = issued[i];
          drive_req(i, op_addr[i][cur], op_wen[i][cur], op_wdata[i][cur], op_be[i][cur]);
          state[i] = 1;
        end
        if (state[i] != 0 || issued[i] < op_cnt[i]) begin
          busy = 1'b1;
        end
      end
      if (busy && cycles >= BatchLimit) begin
        $display("%s: operations did not finish in %0d cycles", name, BatchLimit);
        errors++;
        busy = 1'b0;
      end
    end
    req_valid <= '0;
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  task automatic fill_memory();
    logic [7:0] a;
    clear_ops();
    for (int k = 0; k < MemWords; k++) begin
      a = k[7:0];
      add_op(k % NT, group_pkg::tcdm_addr_t'(k), 1'b1, {8'ha5, a, ~a, a ^ 8'h3c}, '1);
    end
    run_ops("fill", 1'b0);
  endtask

  task automatic test_write_read();
    int err_start;
    err_start = errors;
    clear_ops();
    for (int b = 0; b < NT; b++) begin
      add_op(0, group_pkg::tcdm_addr_t'(3 * NT + b), 1'b1, 32'hc0de_0000 + b * 32'h0101, '1);
    end
    for (int b = 0; b < NT; b++) begin
      add_op(0, group_pkg::tcdm_addr_t'(3 * NT + b), 1'b0, '0, '1);
    end
    run_ops("write_read", 1'b0);
    finish_test("write_read", err_start);
  endtask

  task automatic test_byte_enables();
    int                    err_start;
    group_pkg::tcdm_addr_t addr;
    err_start = errors;
    addr      = group_pkg::tcdm_addr_t'(7 * NT + 1);
    clear_ops();
    add_op(0, addr, 1'b1, 32'h1122_3344, '1);
    add_op(0, addr, 1'b0, '0, '1);
    for (int k = 0; k < group_pkg::StrbW; k++) begin
      add_op(0, addr, 1'b1, 32'ha0b0_c0d0 + k * 32'h0101_0101, group_pkg::strb_t'(1 << k));
      add_op(0, addr, 1'b0, '0, '1);
    end
    run_ops("byte_enables", 1'b0);
    finish_test("byte_enables", err_start);
  endtask

  task automatic test_parallel();
    int                    err_start;
    group_pkg::tcdm_addr_t addr [NT];
    group_pkg::data_t      exp_data [NT];
    err_start = errors;
    @(posedge clk);
    for (int i = 0; i < NT; i++) begin
      // Initiator i reads bank i+1
      addr[i]     = group_pkg::tcdm_addr_t'((16 + i) * NT + (i + 1) % NT);
      exp_data[i] = ref_mem[addr[i]];
      drive_req(i, addr[i], 1'b0, '0, '1);
      resp_ready[i] <= 1'b1;
    end
    @(posedge clk);
    check_eq("parallel", (1 << NT) - 1, req_ready_o);
    check_eq("parallel", 0, resp_valid_o);
    req_valid <= '0;
    @(posedge clk);
    check_eq("parallel", (1 << NT) - 1, resp_valid_o);
    for (int i = 0; i < NT; i++) begin
      check_eq("parallel", exp_data[i], resp_rdata_o[i]);
    end
    finish_test("parallel", err_start);
  endtask

  task automatic test_contention();
    int err_start;
    err_start = errors;
    clear_ops();
    for (int i = 0; i < NT; i++) begin
      for (int j = 0; j < 2; j++) begin
        // Every request lands on bank 2
        add_op(i, group_pkg::tcdm_addr_t'((i * 2 + j) * NT + 2), 1'b0, '0, '1);
      end
    end
    run_ops("contention", 1'b1);
    finish_test("contention", err_start);
  endtask

  task automatic test_backpressure();
    int                    err_start;
    group_pkg::tcdm_addr_t addr_a;
    group_pkg::tcdm_addr_t addr_b;
    group_pkg::data_t      exp_a;
    group_pkg::data_t      exp_b;
    err_start = errors;
    addr_a    = group_pkg::tcdm_addr_t'(5 * NT + 3);
    addr_b    = group_pkg::tcdm_addr_t'(9 * NT + 3);
    exp_a     = ref_mem[addr_a];
    exp_b     = ref_mem[addr_b];
    @(posedge clk);
    drive_req(1, addr_a, 1'b0, '0, '1);
    resp_ready[1] <= 1'b0;
    wait_ready(1, "backpressure");
    req_valid[1] <= 1'b0;
    wait_resp(1, "backpressure");
    check_eq("backpressure", exp_a, resp_rdata_o[1]);
    // Second request to the stalled bank
    drive_req(2, addr_b, 1'b0, '0, '1);
    for (int t = 0; t < 10; t++) begin
      @(posedge clk);
      check_eq("backpressure", 1, resp_valid_o[1]);
      check_eq("backpressure", exp_a, resp_rdata_o[1]);
      check_eq("backpressure", 0, req_ready_o[2]);
    end
    resp_ready[1] <= 1'b1;
    wait_ready(2, "backpressure");
    req_valid[2] <= 1'b0;
    wait_resp(2, "backpressure");
    check_eq("backpressure", exp_b, resp_rdata_o[2]);
    finish_test("backpressure", err_start);
  endtask

  task automatic test_random();
    int                    err_start;
    int                    ini;
    group_pkg::tcdm_addr_t addr;
    logic                  wen;
    group_pkg::data_t      wdata;
    group_pkg::strb_t      be;
    err_start = errors;
    clear_ops();
    for (int k = 0; k < 200; k++) begin
      ini   = int'(take_bits(group_pkg::TileIdxW));
      addr  = group_pkg::tcdm_addr_t'(take_bits(group_pkg::TcdmAddrW));
      wen   = 1'(take_bits(1));
      wdata = take_bits(32);
      be    = group_pkg::strb_t'(take_bits(group_pkg::StrbW));
      add_op(ini, addr, wen, wdata, be);
    end
    run_ops("random", 1'b0);
    finish_test("random", err_start);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    lfsr         = 16'd10;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        <= 1'b0;
    req_valid    <= '0;
    req_tgt_addr <= '0;
    req_wen      <= '0;
    req_wdata    <= '0;
    req_be       <= '0;
    resp_ready   <= '1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    fill_memory();
    test_write_read();
    test_byte_enables();
    test_parallel();
    test_contention();
    test_backpressure();
    test_random();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/mempool_group_checker.sv
/*
 * Handshake checker for the group core ports
 * Bound to mempool_group
 */

`default_nettype none

`include "group_params.svh"

module mempool_group_checker (
  input wire logic                             clk_i,
  input wire logic                             rst_n_i,
  input wire logic             [`NUM_TILES-1:0] req_valid_i,
  input wire logic             [`NUM_TILES-1:0] req_ready_o,
  input wire logic             [`NUM_TILES-1:0] resp_valid_o,
  input wire logic             [`NUM_TILES-1:0] resp_ready_i,
  input wire group_pkg::data_t [`NUM_TILES-1:0] resp_rdata_o
);

  // Response registers come out of reset empty
  resp_idle_after_reset: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> (resp_valid_o == '0)
  ) else $error("resp_valid high in the first cycle after reset");

  for (genvar t = 0; t < `NUM_TILES; t++) begin : gen_port_chk
    resp_held: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (resp_valid_o[t] && !resp_ready_i[t]) |=> (resp_valid_o[t] && $stable(resp_rdata_o[t]))
    ) else $error("tile %0d response dropped or changed while stalled", t);

    no_ready_when_idle: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(req_ready_o[t] && !req_valid_i[t] && resp_valid_o[t] && !resp_ready_i[t])
    ) else $error("tile %0d req_ready high without request during stalled response", t);
  end

endmodule

bind mempool_group mempool_group_checker i_checker (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_valid_i  (req_valid_i),
  .req_ready_o  (req_ready_o),
  .resp_valid_o (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_rdata_o (resp_rdata_o)
);

`default_nettype wire

//--- verilog/mempool_group.sv
/*
 * MemPool group top level
 * Tiles' core ports into the local crossbar with one bank per tile
 */

`default_nettype none

`include "group_params.svh"

module mempool_group (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_n_i,
  // Request channel, one per tile
  input  wire logic                  [`NUM_TILES-1:0] req_valid_i,
  output logic                       [`NUM_TILES-1:0] req_ready_o,
  input  wire group_pkg::tcdm_addr_t [`NUM_TILES-1:0] req_tgt_addr_i,
  input  wire logic                  [`NUM_TILES-1:0] req_wen_i,
  input  wire group_pkg::data_t      [`NUM_TILES-1:0] req_wdata_i,
  input  wire group_pkg::strb_t      [`NUM_TILES-1:0] req_be_i,
  // Response channel, one per tile
  output logic                       [`NUM_TILES-1:0] resp_valid_o,
  input  wire logic                  [`NUM_TILES-1:0] resp_ready_i,
  output group_pkg::data_t           [`NUM_TILES-1:0] resp_rdata_o
);

  tcdm_if ini_bus  [`NUM_TILES] ();
  tcdm_if bank_bus [`NUM_TILES] ();

  // ----------------------------------------
  // Core ports onto the initiator buses
  // ----------------------------------------

  for (genvar t = 0; t < `NUM_TILES; t++) begin : gen_ports
    assign ini_bus[t].req_valid  = req_valid_i[t];
    assign ini_bus[t].tgt_addr   = req_tgt_addr_i[t];
    // Source id that the crossbar ignores
    assign ini_bus[t].ini_addr   = group_pkg::tile_idx_t'(t);
    assign ini_bus[t].wen        = req_wen_i[t];
    assign ini_bus[t].wdata      = req_wdata_i[t];
    assign ini_bus[t].be         = req_be_i[t];
    assign ini_bus[t].resp_ready = resp_ready_i[t];
    assign req_ready_o[t]        = ini_bus[t].req_ready;
    assign resp_valid_o[t]       = ini_bus[t].resp_valid;
    assign resp_rdata_o[t]       = ini_bus[t].rdata;
  end

  // ----------------------------------------
  // Crossbar and banks
  // ----------------------------------------

  local_interco i_local_interco (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .ini_bus  (ini_bus),
    .bank_bus (bank_bus)
  );

  for (genvar t = 0; t < `NUM_TILES; t++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .bus     (bank_bus[t])
    );
  end

endmodule

`default_nettype wire

//--- tile/tcdm_bank.sv
/*
 * TCDM bank of one tile
 * Byte-enable writes and a one-entry response register with requester id
 */

`default_nettype none

`include "group_params.svh"

module tcdm_bank (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  tcdm_if.target    bus
);

  group_pkg::data_t mem [`BANK_WORDS];

  group_pkg::bank_addr_t row;
  logic                  accept;

  logic                  resp_valid_q;
  group_pkg::data_t      rdata_q;
  group_pkg::tile_idx_t  resp_ini_q;

  // Only the row bits reach the bank
  assign row = group_pkg::bank_addr_t'(bus.tgt_addr);

  // Room when empty or draining this cycle
  assign bus.req_ready = !resp_valid_q || bus.resp_ready;
  assign accept        = bus.req_valid && bus.req_ready;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (accept && bus.wen) begin
      for (int k = 0; k < group_pkg::StrbW; k++) begin
        if (bus.be[k]) begin
          mem[row][8*k +: 8] <= bus.wdata[8*k +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Response register
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (bus.resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Old row content read before the write lands
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q    <= mem[row];
      resp_ini_q <= bus.ini_addr;
    end
  end

  assign bus.resp_valid = resp_valid_q;
  assign bus.rdata      = rdata_q;
  assign bus.resp_ini   = resp_ini_q;

endmodule

`default_nettype wire

//--- interco/local_interco.sv
/*
 * Local interconnect of the group
 * Full crossbar with per-bank request and per-initiator response arbitration
 */

`default_nettype none

`include "group_params.svh"

module local_interco (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  tcdm_if.target     ini_bus  [`NUM_TILES],
  tcdm_if.initiator  bank_bus [`NUM_TILES]
);

  localparam int unsigned N = `NUM_TILES;

  // Initiator side
  logic [N-1:0]          ini_valid;
  logic [N-1:0]          ini_req_ready;
  group_pkg::tile_idx_t  ini_tile [N];
  group_pkg::bank_addr_t ini_row [N];
  logic [N-1:0]          ini_wen;
  group_pkg::data_t      ini_wdata [N];
  group_pkg::strb_t      ini_be [N];
  logic [N-1:0]          ini_resp_valid;
  logic [N-1:0]          ini_resp_ready;
  group_pkg::data_t      ini_rdata [N];

  // Bank side
  logic [N-1:0]          bk_req_valid;
  logic [N-1:0]          bk_req_ready;
  group_pkg::bank_addr_t bk_row [N];
  group_pkg::tile_idx_t  bk_ini [N];
  logic [N-1:0]          bk_wen;
  group_pkg::data_t      bk_wdata [N];
  group_pkg::strb_t      bk_be [N];
  logic [N-1:0]          bk_resp_valid;
  logic [N-1:0]          bk_resp_ready;
  group_pkg::data_t      bk_rdata [N];
  group_pkg::tile_idx_t  bk_resp_ini [N];

  // Arbitration indexed [bank][initiator] and [initiator][bank]
  logic [N-1:0] bank_req [N];
  logic [N-1:0] bank_gnt [N];
  logic [N-1:0] bank_ack;
  logic [N-1:0] ret_req [N];
  logic [N-1:0] ret_gnt [N];
  logic [N-1:0] ret_ack;

  // ----------------------------------------
  // Interface flattening
  // ----------------------------------------

  for (genvar i = 0; i < N; i++) begin : gen_ini_flat
    assign ini_valid[i]          = ini_bus[i].req_valid;
    // Low address bits pick the tile
    assign ini_tile[i]           = ini_bus[i].tgt_addr[group_pkg::TileIdxW-1:0];
    assign ini_row[i]            =
      ini_bus[i].tgt_addr[group_pkg::TileIdxW +: group_pkg::BankAddrW];
    assign ini_wen[i]            = ini_bus[i].wen;
    assign ini_wdata[i]          = ini_bus[i].wdata;
    assign ini_be[i]             = ini_bus[i].be;
    assign ini_resp_ready[i]     = ini_bus[i].resp_ready;
    assign ini_bus[i].req_ready  = ini_req_ready[i];
    assign ini_bus[i].resp_valid = ini_resp_valid[i];
    assign ini_bus[i].rdata      = ini_rdata[i];
    assign ini_bus[i].resp_ini   = group_pkg::tile_idx_t'(i);
  end

  for (genvar b = 0; b < N; b++) begin : gen_bank_flat
    assign bank_bus[b].req_valid  = bk_req_valid[b];
    assign bank_bus[b].tgt_addr   = group_pkg::tcdm_addr_t'(bk_row[b]);
    assign bank_bus[b].ini_addr   = bk_ini[b];
    assign bank_bus[b].wen        = bk_wen[b];
    assign bank_bus[b].wdata      = bk_wdata[b];
    assign bank_bus[b].be         = bk_be[b];
    assign bank_bus[b].resp_ready = bk_resp_ready[b];
    assign bk_req_ready[b]        = bank_bus[b].req_ready;
    assign bk_resp_valid[b]       = bank_bus[b].resp_valid;
    assign bk_rdata[b]            = bank_bus[b].rdata;
    assign bk_resp_ini[b]         = bank_bus[b].resp_ini;
  end

  // ----------------------------------------
  // Request path
  // ----------------------------------------

  always_comb begin
    for (int b = 0; b < N; b++) begin
      for (int i = 0; i < N; i++) begin
        bank_req[b][i] = ini_valid[i] && (ini_tile[i] == group_pkg::tile_idx_t'(b));
      end
    end
  end

  always_comb begin
    for (int b = 0; b < N; b++) begin
      bk_req_valid[b] = |bank_req[b];
      bk_row[b]       = '0;
      bk_ini[b]       = '0;
      bk_wen[b]       = 1'b0;
      bk_wdata[b]     = '0;
      bk_be[b]        = '0;
      for (int i = 0; i < N; i++) begin
        if (bank_gnt[b][i]) begin
          bk_row[b]   = ini_row[i];
          bk_ini[b]   = group_pkg::tile_idx_t'(i);
          bk_wen[b]   = ini_wen[i];
          bk_wdata[b] = ini_wdata[i];
          bk_be[b]    = ini_be[i];
        end
      end
    end
  end

  assign bank_ack = bk_req_valid & bk_req_ready;

  // Ready only to the winner of the addressed bank
  always_comb begin
    ini_req_ready = '0;
    for (int i = 0; i < N; i++) begin
      for (int b = 0; b < N; b++) begin
        ini_req_ready[i] = ini_req_ready[i] | (bank_gnt[b][i] & bk_req_ready[b]);
      end
    end
  end

  // ----------------------------------------
  // Response path
  // ----------------------------------------

  always_comb begin
    for (int i = 0; i < N; i++) begin
      for (int b = 0; b < N; b++) begin
        ret_req[i][b] = bk_resp_valid[b] && (bk_resp_ini[b] == group_pkg::tile_idx_t'(i));
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      ini_resp_valid[i] = |ret_req[i];
      ini_rdata[i]      = '0;
      for (int b = 0; b < N; b++) begin
        if (ret_gnt[i][b]) begin
          ini_rdata[i] = bk_rdata[b];
        end
      end
    end
  end

  assign ret_ack = ini_resp_valid & ini_resp_ready;

  always_comb begin
    bk_resp_ready = '0;
    for (int b = 0; b < N; b++) begin
      for (int i = 0; i < N; i++) begin
        bk_resp_ready[b] = bk_resp_ready[b] | (ret_gnt[i][b] & ini_resp_ready[i]);
      end
    end
  end

  // ----------------------------------------
  // Arbiters
  // ----------------------------------------

  for (genvar k = 0; k < N; k++) begin : gen_arb
    rr_arbiter #(
      .NumReq (N)
    ) i_req_arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (bank_req[k]),
      .ack_i   (bank_ack[k]),
      .gnt_o   (bank_gnt[k])
    );

    rr_arbiter #(
      .NumReq (N)
    ) i_resp_arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (ret_req[k]),
      .ack_i   (ret_ack[k]),
      .gnt_o   (ret_gnt[k])
    );
  end

endmodule

`default_nettype wire

//--- interco/rr_arbiter.sv
/*
 * Round-robin arbiter
 * Rotating priority pointer that moves one past the winner on each transfer
 */

`default_nettype none

module rr_arbiter #(
  parameter int unsigned NumReq = 4
) (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic [NumReq-1:0] req_i,
  input  wire logic              ack_i,
  output logic      [NumReq-1:0] gnt_o
);

  localparam int unsigned PtrW = (NumReq > 1) ? $clog2(NumReq) : 1;

  typedef logic [PtrW-1:0] ptr_t;

  ptr_t ptr_q;
  ptr_t win;

  // ----------------------------------------
  // Grant the first request at or after ptr
  // ----------------------------------------

  always_comb begin
    int unsigned idx;
    logic        found;
    gnt_o = '0;
    win   = ptr_q;
    found = 1'b0;
    for (int unsigned k = 0; k < NumReq; k++) begin
      idx = (ptr_q + k) % NumReq;
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        gnt_o[idx] = 1'b1;
        win        = ptr_t'(idx);
      end
    end
  end

  // ----------------------------------------
  // Pointer update
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (ack_i) begin
      // Winner drops to lowest priority
      if (win == ptr_t'(NumReq - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- common/tcdm_if.sv
/*
 * TCDM channel
 * One request/response pair with valid/ready on each direction
 */

`default_nettype none

interface tcdm_if;

  // Request direction
  logic                  req_valid;
  logic                  req_ready;
  group_pkg::tcdm_addr_t tgt_addr;
  group_pkg::tile_idx_t  ini_addr;
  logic                  wen;
  group_pkg::data_t      wdata;
  group_pkg::strb_t      be;

  // Response direction
  logic                  resp_valid;
  logic                  resp_ready;
  group_pkg::data_t      rdata;
  // Requester id travelling back with the response
  group_pkg::tile_idx_t  resp_ini;

  modport initiator (
    output req_valid, tgt_addr, ini_addr, wen, wdata, be, resp_ready,
    input  req_ready, resp_valid, rdata, resp_ini
  );

  modport target (
    input  req_valid, tgt_addr, ini_addr, wen, wdata, be, resp_ready,
    output req_ready, resp_valid, rdata, resp_ini
  );

endinterface

`default_nettype wire

//--- common/group_pkg.sv
/*
 * MemPool group package
 * Widths and vector types shared across the group
 */

`default_nettype none

`include "group_params.svh"

package group_pkg;

  localparam int unsigned TileIdxW  = $clog2(`NUM_TILES);
  localparam int unsigned BankAddrW = $clog2(`BANK_WORDS);
  localparam int unsigned TcdmAddrW = BankAddrW + TileIdxW;
  localparam int unsigned StrbW     = `DATA_WIDTH / 8;

  // Tile select that doubles as initiator id
  typedef logic [TileIdxW-1:0]    tile_idx_t;
  typedef logic [BankAddrW-1:0]   bank_addr_t;
  // Bank row in the upper bits and tile index in the lower
  typedef logic [TcdmAddrW-1:0]   tcdm_addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [StrbW-1:0]       strb_t;

endpackage

`default_nettype wire

//--- common/group_params.svh
/*
 * MemPool group dimensions
 * Tile count, bank depth and data word width
 */

`ifndef GROUP_PARAMS_SVH
`define GROUP_PARAMS_SVH

// Tiles, initiators and banks in the group
`define NUM_TILES 4

// Words held by each tile's bank
`define BANK_WORDS 64

// Data word width in bits
`define DATA_WIDTH 32

`endif
